//--- files.f
+incdir+rtl
rtl/leaf_pkg.sv
rtl/packet_decoder.sv
rtl/port_fifo.sv
rtl/output_packetizer.sv
rtl/leaf_top.sv
tests/leaf_assertions.sv
tests/leaf_tb.sv

//--- Makefile
TOP := leaf_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- tests/leaf_tb.sv
`timescale 1ns/1ps
`include "leaf_defines.svh"

module leaf_tb;
    import leaf_pkg::*;

    localparam int         TIMEOUT = 200;
    localparam logic [4:0] LEAF    = `DEFAULT_LEAF_ID;

    logic                        clk;
    logic                        arst_n;
    logic                        resend;
    packet_t                     din;
    packet_t                     dout;
    user_word_t [`NUM_PORTS-1:0] user_in_data;
    user_word_t [`NUM_PORTS-1:0] user_out_data;
    logic [`NUM_PORTS-1:0]       user_in_vld;
    logic [`NUM_PORTS-1:0]       user_in_ack;
    logic [`NUM_PORTS-1:0]       user_out_vld;
    logic [`NUM_PORTS-1:0]       user_out_ack;
    logic [7:0]                  drop_count;

    integer                seed = 32'hbf01_1578;
    user_word_t            in_exp [`NUM_PORTS][$];   // Words due at each user input port
    user_word_t            tx_q [`NUM_PORTS][$];     // Kernel words not yet taken
    user_word_t            exp_q [`NUM_PORTS][$];    // Words due back in dout
    packet_t               rx_pkts [$];
    int                    ack_log [$];
    logic [4:0]            cfg_leaf [`NUM_PORTS];
    logic [3:0]            cfg_port [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] cfg_en;
    logic [SEQ_BITS-1:0]   exp_seq [`NUM_PORTS];

    leaf_top #(.LEAF_ID(LEAF)) leaf_top_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .din           (din),
        .dout          (dout),
        .resend        (resend),
        .user_in_data  (user_in_data),
        .user_in_vld   (user_in_vld),
        .user_in_ack   (user_in_ack),
        .user_out_data (user_out_data),
        .user_out_vld  (user_out_vld),
        .user_out_ack  (user_out_ack),
        .drop_count    (drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_packet(input string name, input packet_t got, input packet_t exp);
        if (got !== exp) begin
            abort_run({$sformatf("** Error: %s got valid=%h leaf=%h port=%h seq=%h data=%h",
                                 name, got.valid, got.leaf, got.port, got.seq, got.payload.data),
                       $sformatf(" expected valid=%h leaf=%h port=%h seq=%h data=%h",
                                 exp.valid, exp.leaf, exp.port, exp.seq, exp.payload.data)});
        end
    endtask

    task automatic check_word(input string name, input user_word_t got, input user_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic packet_t make_packet(input logic valid, input logic [4:0] leaf,
                                            input logic [3:0] port,
                                            input logic [SEQ_BITS-1:0] seq,
                                            input user_word_t word);
        packet_t p;
        p.valid        = valid;
        p.leaf         = leaf;
        p.port         = port;
        p.seq          = seq;
        p.payload.data = word;
        return p;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_packet(input packet_t p);
        din = p;
        next_cycle();
        din = '0;
    endtask

    task automatic wait_in_vld(input int p);
        int n = 0;
        while (!user_in_vld[p]) begin
            if (n == TIMEOUT) abort_run($sformatf("Timeout waiting for user_in_vld[%0d]", p));
            n++;
            next_cycle();
        end
    endtask

    task automatic wait_rx(input int count);
        int n = 0;
        while (rx_pkts.size() < count) begin
            if (n == TIMEOUT) abort_run($sformatf("Timeout waiting for %0d packets in dout", count));
            n++;
            next_cycle();
        end
    endtask

    task automatic take_in_word(input int p);
        wait_in_vld(p);
        check_word($sformatf("user_in_data[%0d]", p), user_in_data[p], in_exp[p].pop_front());
        user_in_ack[p] = 1'b1;
        next_cycle();
        user_in_ack[p] = 1'b0;
    endtask

    task automatic queue_words(input int p, input int count);
        user_word_t w;
        repeat (count) begin
            w = $random(seed);
            tx_q[p].push_back(w);
            exp_q[p].push_back(w);
        end
    endtask

    task automatic configure_port(input int p, input logic [4:0] leaf, input logic [3:0] port,
                                  input logic en);
        port_cfg_t c;
        c           = '0;
        c.out_port  = 2'(p);
        c.dest_leaf = leaf;
        c.dest_port = port;
        c.enable    = en;
        cfg_leaf[p] = leaf;
        cfg_port[p] = port;
        cfg_en[p]   = en;
        send_packet(make_packet(1'b1, LEAF, 4'd0, '0, c));
    endtask

    // Pairs each dout packet with the grant that produced it
    task automatic check_outputs(input int count);
        int p;
        wait_rx(count);
        repeat (count) begin
            p = ack_log.pop_front();
            check_packet("dout", rx_pkts.pop_front(),
                make_packet(1'b1, cfg_leaf[p], cfg_port[p], exp_seq[p], exp_q[p].pop_front()));
            exp_seq[p] = exp_seq[p] + 1'b1;
        end
        repeat (4) next_cycle();
        if (rx_pkts.size() != 0 || ack_log.size() != 0) abort_run("Extra packet or grant seen");
    endtask

    initial begin : tree_monitor
        forever begin
            @(negedge clk);
            if (resend && dout !== '0) abort_run("dout was not zero while resend was high");
            if (resend && user_out_ack != '0) abort_run("A user output port was acked during resend");
            if ((user_out_ack & ~cfg_en) != '0) abort_run("A disabled user output port was acked");
            for (int i = 0; i < `NUM_PORTS; i++) begin
                if (user_out_ack[i]) ack_log.push_back(i);
            end
            if (dout.valid) rx_pkts.push_back(dout);
        end
    end

    // Output side of the user kernel, holds each word until its ack
    initial begin : user_kernel
        logic [`NUM_PORTS-1:0] taken;
        user_out_vld  = '0;
        user_out_data = '0;
        forever begin
            @(negedge clk);
            taken = user_out_ack;
            next_cycle();
            for (int i = 0; i < `NUM_PORTS; i++) begin
                if (taken[i]) tx_q[i].delete(0);
                user_out_vld[i]  = (tx_q[i].size() != 0);
                user_out_data[i] = (tx_q[i].size() != 0) ? tx_q[i][0] : '0;
            end
        end
    end

    task automatic test_delivery();
        user_word_t w;
        for (int n = 0; n < 3; n++) begin
            for (int p = 0; p < `NUM_PORTS; p++) begin
                w = $random(seed);
                in_exp[p].push_back(w);
                send_packet(make_packet(1'b1, LEAF, 4'(p + 1), '0, w));
            end
        end
        for (int p = 0; p < `NUM_PORTS; p++) begin
            while (in_exp[p].size() != 0) take_in_word(p);
        end
        if (user_in_vld != '0) abort_run("user_in_vld stayed high after the last word");
    endtask

    task automatic test_filtering();
        send_packet(make_packet(1'b1, LEAF + 5'd1, 4'd1, '0, $random(seed)));
        send_packet(make_packet(1'b0, LEAF, 4'd2, '0, $random(seed)));
        send_packet(make_packet(1'b1, LEAF, 4'd5, '0, $random(seed)));
        send_packet(make_packet(1'b1, LEAF, 4'd15, '0, $random(seed)));
        repeat (6) begin
            if (user_in_vld != '0) abort_run("A filtered packet reached a user input port");
            next_cycle();
        end
        check_count("drop_count", drop_count, 8'd0);
    endtask

    task automatic test_overflow();
        user_word_t w;
        for (int n = 0; n < 6; n++) begin
            w = $random(seed);
            if (n < `FIFO_DEPTH) in_exp[2].push_back(w);
            send_packet(make_packet(1'b1, LEAF, 4'd3, '0, w));
        end
        next_cycle();
        check_count("drop_count", drop_count, 8'd2);
        while (in_exp[2].size() != 0) take_in_word(2);
        if (user_in_vld != '0) abort_run("user_in_vld stayed high after overflow drain");
    endtask

    task automatic test_framing();
        for (int p = 0; p < `NUM_PORTS; p++) begin
            configure_port(p, 5'(3 * p + 4), 4'(p + 1), p != 3);
        end
        for (int p = 0; p < 3; p++) queue_words(p, 3);
        queue_words(3, 2);
        check_outputs(9);
        configure_port(3, 5'd17, 4'd9, 1'b1);
        check_outputs(2);
    endtask

    task automatic test_fairness();
        int                    hits [`NUM_PORTS] = '{default: 0};
        logic [`NUM_PORTS-1:0] first = '0;
        for (int p = 0; p < `NUM_PORTS; p++) queue_words(p, 2);
        wait_rx(8);
        for (int k = 0; k < 8; k++) begin
            if (k < `NUM_PORTS) first[ack_log[k]] = 1'b1;
            hits[ack_log[k]]++;
        end
        if (first != '1) abort_run("A port was granted twice before all four had a grant");
        for (int p = 0; p < `NUM_PORTS; p++) begin
            if (hits[p] != 2) abort_run($sformatf("Port %0d got %0d of eight grants", p, hits[p]));
        end
        check_outputs(8);
    endtask

    task automatic test_resend();
        for (int p = 0; p < `NUM_PORTS; p++) queue_words(p, 2);
        wait_rx(1);
        resend = 1'b1;    // Second packet is now held in the output register
        repeat (8) next_cycle();
        resend = 1'b0;
        check_outputs(8);
    endtask

    initial begin
        arst_n      = 1'b1;
        resend      = 1'b0;
        din         = '0;
        user_in_ack = '0;
        cfg_en      = '0;
        for (int i = 0; i < `NUM_PORTS; i++) exp_seq[i] = '0;
        #1 arst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1 arst_n = 1'b1;
        test_delivery();
        test_filtering();
        test_overflow();
        test_framing();
        test_fairness();
        test_resend();
        $display("Regression passed");
        $finish;
    end

endmodule

//--- tests/leaf_assertions.sv
`timescale 1ns/1ps
`include "leaf_defines.svh"

module leaf_assertions (
    input logic                  clk,
    input logic                  arst_n,
    input leaf_pkg::packet_t     dout,
    input logic                  resend,
    input logic [`NUM_PORTS-1:0] user_in_vld,
    input logic [`NUM_PORTS-1:0] user_out_vld,
    input logic [`NUM_PORTS-1:0] user_out_ack,
    input logic [7:0]            drop_count
);

    // One grant per cycle at most
    ack_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(user_out_ack))
        else $error("user_out_ack has more than one bit set");

    ack_needs_vld: assert property (@(posedge clk) disable iff (!arst_n)
        (user_out_ack & ~user_out_vld) == '0)
        else $error("user_out_ack given to a port without vld");

    dout_gated: assert property (@(posedge clk) disable iff (!arst_n)
        resend |-> dout == '0)
        else $error("dout not zero while resend is high");

    // First edge after reset release
    quiet_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> (user_in_vld == '0 && user_out_ack == '0
                           && dout == '0 && drop_count == 8'd0))
        else $error("Output active right after reset");

endmodule

bind leaf_top leaf_assertions leaf_assertions_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .dout         (dout),
    .resend       (resend),
    .user_in_vld  (user_in_vld),
    .user_out_vld (user_out_vld),
    .user_out_ack (user_out_ack),
    .drop_count   (drop_count)
);

//--- rtl/leaf_top.sv
`timescale 1ns/1ps
`include "leaf_defines.svh"

module leaf_top #(
    parameter logic [4:0] LEAF_ID = `DEFAULT_LEAF_ID
) (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  leaf_pkg::packet_t                     din,
    output leaf_pkg::packet_t                     dout,
    input  logic                                  resend,
    output leaf_pkg::user_word_t [`NUM_PORTS-1:0] user_in_data,
    output logic [`NUM_PORTS-1:0]                 user_in_vld,
    input  logic [`NUM_PORTS-1:0]                 user_in_ack,
    input  leaf_pkg::user_word_t [`NUM_PORTS-1:0] user_out_data,
    input  logic [`NUM_PORTS-1:0]                 user_out_vld,
    output logic [`NUM_PORTS-1:0]                 user_out_ack,
    output logic [7:0]                            drop_count
);
    import leaf_pkg::*;

    logic [`NUM_PORTS-1:0] fifo_wr;
    user_word_t            fifo_data;
    logic                  cfg_wr;
    port_cfg_t             cfg;
    logic [`NUM_PORTS-1:0] drop;

    packet_decoder packet_decoder_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .din       (din),
        .leaf_id   (LEAF_ID),
        .fifo_wr   (fifo_wr),
        .fifo_data (fifo_data),
        .cfg_wr    (cfg_wr),
        .cfg       (cfg)
    );

    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_in_port
        port_fifo port_fifo_inst (
            .clk     (clk),
            .arst_n  (arst_n),
            .wr      (fifo_wr[i]),
            .wr_data (fifo_data),
            .vld     (user_in_vld[i]),
            .data    (user_in_data[i]),
            .ack     (user_in_ack[i]),
            .drop    (drop[i])
        );
    end

    output_packetizer output_packetizer_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .cfg_wr        (cfg_wr),
        .cfg           (cfg),
        .user_out_vld  (user_out_vld),
        .user_out_data (user_out_data),
        .user_out_ack  (user_out_ack),
        .resend        (resend),
        .dout          (dout)
    );

    // At most one FIFO is written per cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            drop_count <= '0;
        end else if (|drop && drop_count != 8'hff) begin
            drop_count <= drop_count + 8'd1;    // Saturates
        end
    end

endmodule

//--- rtl/output_packetizer.sv
`timescale 1ns/1ps
`include "leaf_defines.svh"

module output_packetizer (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     cfg_wr,
    input  leaf_pkg::port_cfg_t                      cfg,
    input  logic [`NUM_PORTS-1:0]                    user_out_vld,
    input  leaf_pkg::user_word_t [`NUM_PORTS-1:0]    user_out_data,
    output logic [`NUM_PORTS-1:0]                    user_out_ack,
    input  logic                                     resend,
    output leaf_pkg::packet_t                        dout
);
    import leaf_pkg::*;

    localparam int PTR_W = $clog2(`NUM_PORTS);

    // Per output port destination
    logic [`NUM_PORTS-1:0] enable_q;
    logic [4:0]            dest_leaf_q [`NUM_PORTS];
    logic [3:0]            dest_port_q [`NUM_PORTS];
    logic [SEQ_BITS-1:0]   seq_q [`NUM_PORTS];

    logic [PTR_W-1:0]      rr_q;      // Last port granted
    logic [`NUM_PORTS-1:0] req;
    logic [PTR_W-1:0]      cand;
    logic [PTR_W-1:0]      gnt_idx;
    logic                  gnt_any;
    logic                  can_grant;
    logic                  gnt_fire;

    logic                  out_vld_q;
    packet_t               out_pkt_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enable_q <= '0;
        end else if (cfg_wr) begin
            enable_q[cfg.out_port] <= cfg.enable;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_wr) begin
            dest_leaf_q[cfg.out_port] <= cfg.dest_leaf;
            dest_port_q[cfg.out_port] <= cfg.dest_port;
        end
    end

    assign req = user_out_vld & enable_q;

    // The output register empties every cycle that resend is low,
    // so a new packet can follow the one leaving now
    assign can_grant = !resend;

    // Walk downward so the port closest after rr_q wins
    always_comb begin
        gnt_any = 1'b0;
        gnt_idx = rr_q;
        cand    = rr_q;
        for (int k = `NUM_PORTS; k >= 1; k--) begin
            cand = PTR_W'((int'(rr_q) + k) % `NUM_PORTS);
            if (req[cand]) begin
                gnt_any = 1'b1;
                gnt_idx = cand;
            end
        end
    end

    assign gnt_fire = gnt_any && can_grant;

    always_comb begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            user_out_ack[i] = gnt_fire && (gnt_idx == PTR_W'(i));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rr_q      <= '0;
            out_vld_q <= 1'b0;
            for (int i = 0; i < `NUM_PORTS; i++) begin
                seq_q[i] <= '0;
            end
        end else begin
            if (gnt_fire) begin
                rr_q           <= gnt_idx;
                seq_q[gnt_idx] <= seq_q[gnt_idx] + 1'b1;   // Wraps at 128
                out_vld_q      <= 1'b1;
            end else if (!resend) begin
                out_vld_q      <= 1'b0;
            end
        end
    end

    // Framing of the granted word
    always_ff @(posedge clk) begin
        if (gnt_fire) begin
            out_pkt_q.valid        <= 1'b1;
            out_pkt_q.leaf         <= dest_leaf_q[gnt_idx];
            out_pkt_q.port         <= dest_port_q[gnt_idx];
            out_pkt_q.seq          <= seq_q[gnt_idx];
            out_pkt_q.payload.data <= user_out_data[gnt_idx];
        end
    end

    // Held packet stays hidden while the tree asks for resend
    assign dout = (out_vld_q && !resend) ? out_pkt_q : '0;

endmodule

//--- rtl/port_fifo.sv
`timescale 1ns/1ps
`include "leaf_defines.svh"

module port_fifo (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 wr,
    input  leaf_pkg::user_word_t wr_data,
    output logic                 vld,
    output leaf_pkg::user_word_t data,
    input  logic                 ack,
    output logic                 drop
);
    import leaf_pkg::*;

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

    user_word_t       mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == CNT_W'(`FIFO_DEPTH));
    assign push = wr && !full;
    assign pop  = ack && vld;    // Stray ack is ignored
    assign drop = wr && full;

    assign vld  = (count != '0);
    assign data = mem[rd_ptr];   // Head word

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rtl/packet_decoder.sv
`timescale 1ns/1ps
`include "leaf_defines.svh"

module packet_decoder (
    input  logic                          clk,
    input  logic                          arst_n,
    input  leaf_pkg::packet_t             din,
    input  logic [4:0]                    leaf_id,
    output logic [`NUM_PORTS-1:0]         fifo_wr,
    output leaf_pkg::user_word_t          fifo_data,
    output logic                          cfg_wr,
    output leaf_pkg::port_cfg_t           cfg
);
    import leaf_pkg::*;

    logic       hit_q;
    logic [3:0] port_q;
    payload_u   payload_q;

    // Address match is done on the way in
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= din.valid && (din.leaf == leaf_id);
        end
    end

    always_ff @(posedge clk) begin
        port_q    <= din.port;
        payload_q <= din.payload;
    end

    // Port 0 carries configuration, ports 1 to NUM_PORTS map to the FIFOs
    always_comb begin
        cfg_wr = hit_q && (port_q == 4'd0);
        for (int i = 0; i < `NUM_PORTS; i++) begin
            fifo_wr[i] = hit_q && (port_q == 4'(i + 1));
        end
    end

    assign fifo_data = payload_q.data;
    assign cfg       = payload_q.cfg;

endmodule

//--- rtl/leaf_pkg.sv
`include "leaf_defines.svh"

package leaf_pkg;

    // Whatever remains of the packet after valid, leaf, port and payload
    localparam int SEQ_BITS = `PACKET_BITS - 1 - 5 - 4 - `PAYLOAD_BITS;

    typedef logic [`PAYLOAD_BITS-1:0] user_word_t;

    // Payload of a port 0 packet
    typedef struct packed {
        logic [19:0] reserved;
        logic        enable;
        logic [3:0]  dest_port;
        logic [4:0]  dest_leaf;
        logic [1:0]  out_port;    // User output port being set up
    } port_cfg_t;

    typedef union packed {
        user_word_t data;
        port_cfg_t  cfg;
    } payload_u;

    typedef struct packed {
        logic                valid;
        logic [4:0]          leaf;
        logic [3:0]          port;    // 0 is configuration, 1 to 4 are user ports
        logic [SEQ_BITS-1:0] seq;
        payload_u            payload;
    } packet_t;

endpackage

//--- rtl/leaf_defines.svh
`ifndef LEAF_DEFINES_SVH
`define LEAF_DEFINES_SVH

// Tree packet and user word widths
`define PACKET_BITS 49
`define PAYLOAD_BITS 32

// User input ports and user output ports, same count on both sides
`define NUM_PORTS 4

// Words per user input FIFO
`define FIFO_DEPTH 4

// Address of this leaf unless overridden at leaf_top
`define DEFAULT_LEAF_ID 5'd2

`endif
